// ==== common/isa_pkg.sv ====
// Core ISA definitions
`default_nettype none

package isa_pkg;

    localparam int NUM_REGS = 64;

    // Architectural register value and register number
    typedef logic [63:0] word_t;
    typedef logic [5:0]  reg_idx_t;

    // Fixed 32-bit instruction word
    typedef logic [31:0] inst_t;

    // Instruction field positions
    localparam int IMM_FORM_BIT = 31;
    localparam int OP_MSB       = 30;
    localparam int OP_LSB       = 28;
    localparam int RD_MSB       = 27;
    localparam int RD_LSB       = 22;
    localparam int RS1_MSB      = 21;
    localparam int RS1_LSB      = 16;
    localparam int RS2_MSB      = 15;
    localparam int RS2_LSB      = 10;
    localparam int IMM_MSB      = 15;
    localparam int IMM_LSB      = 0;

    // ALU operation codes with code 7 reserved and executed as add
    typedef enum logic [2:0] {
        ALU_ADD  = 3'd0,
        ALU_SUB  = 3'd1,
        ALU_AND  = 3'd2,
        ALU_OR   = 3'd3,
        ALU_XOR  = 3'd4,
        ALU_SHL  = 3'd5,
        ALU_SHR  = 3'd6,
        ALU_RSVD = 3'd7
    } alu_op_t;

endpackage

`default_nettype wire

// ==== common/pipe_pkg.sv ====
// Pipeline shared types
`default_nettype none

package pipe_pkg;

    // Byte address of an instruction
    typedef logic [63:0] pc_t;

    // One busy flag per architectural register
    typedef logic [isa_pkg::NUM_REGS-1:0] busy_vec_t;

    // Program counter step for the fixed 32-bit encoding
    localparam pc_t INST_BYTES = 64'd4;

endpackage

`default_nettype wire

// ==== design/commit.sv ====
// Commit and writeback stage
`timescale 1ns/100ps
`default_nettype none

module commit (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              ex_valid,
    input  isa_pkg::reg_idx_t ex_rn,
    input  isa_pkg::word_t    ex_result,
    input  pipe_pkg::pc_t     ex_pc,
    output logic              wb_en,
    output isa_pkg::reg_idx_t wb_rn,
    output isa_pkg::word_t    wb_data,
    output pipe_pkg::pc_t     retire_pc
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_en <= 1'b0;
        end else begin
            wb_en <= ex_valid;
        end
    end

    // Writeback payload doubles as the retire trace
    always_ff @(posedge clk) begin
        if (ex_valid) begin
            wb_rn     <= ex_rn;
            wb_data   <= ex_result;
            retire_pc <= ex_pc;
        end
    end

endmodule

`default_nettype wire

// ==== design/decode.sv ====
// Instruction decode and issue
`timescale 1ns/100ps
`default_nettype none

module decode (
    input  logic               clk,
    input  logic               rst_n,
    input  isa_pkg::inst_t     fe_inst,
    input  pipe_pkg::pc_t      fe_pc,
    input  logic               fe_valid,
    output logic               de_ready,
    output isa_pkg::reg_idx_t  rs1_rn,
    output isa_pkg::reg_idx_t  rs2_rn,
    output isa_pkg::reg_idx_t  rd_rn,
    output isa_pkg::alu_op_t   op,
    output logic               imm_form,
    output isa_pkg::word_t     imm,
    output pipe_pkg::pc_t      pc,
    input  pipe_pkg::busy_vec_t busy_vec,
    output logic               issue
);

    isa_pkg::inst_t inst_q;
    pipe_pkg::pc_t  pc_q;
    logic           valid_q;
    logic           hazard;

    // Field extraction
    assign imm_form = inst_q[isa_pkg::IMM_FORM_BIT];
    assign op       = isa_pkg::alu_op_t'(inst_q[isa_pkg::OP_MSB:isa_pkg::OP_LSB]);
    assign rd_rn    = inst_q[isa_pkg::RD_MSB:isa_pkg::RD_LSB];
    assign rs1_rn   = inst_q[isa_pkg::RS1_MSB:isa_pkg::RS1_LSB];
    assign rs2_rn   = inst_q[isa_pkg::RS2_MSB:isa_pkg::RS2_LSB];
    assign imm      = isa_pkg::word_t'($signed(inst_q[isa_pkg::IMM_MSB:isa_pkg::IMM_LSB]));
    assign pc       = pc_q;

    // rs2 field overlaps the immediate in immediate form
    assign hazard = busy_vec[rs1_rn] || busy_vec[rd_rn] || (!imm_form && busy_vec[rs2_rn]);
    assign issue    = valid_q && !hazard;
    assign de_ready = !valid_q || issue;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (fe_valid && de_ready) begin
            valid_q <= 1'b1;
        end else if (issue) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (fe_valid && de_ready) begin
            inst_q <= fe_inst;
            pc_q   <= fe_pc;
        end
    end

endmodule

`default_nettype wire

// ==== design/ex_alu.sv ====
// Integer ALU execute stage
`timescale 1ns/100ps
`default_nettype none

module ex_alu (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              issue,
    input  isa_pkg::alu_op_t  op,
    input  logic              imm_form,
    input  isa_pkg::word_t    imm,
    input  isa_pkg::reg_idx_t rd_rn,
    input  pipe_pkg::pc_t     pc,
    input  isa_pkg::word_t    rs1_data,
    input  isa_pkg::word_t    rs2_data,
    output logic              ex_valid,
    output isa_pkg::reg_idx_t ex_rn,
    output isa_pkg::word_t    ex_result,
    output pipe_pkg::pc_t     ex_pc
);

    isa_pkg::word_t operand_b;
    isa_pkg::word_t result;
    logic [5:0]     shamt;

    assign operand_b = imm_form ? imm : rs2_data;
    // Only the low 6 bits count for a 64-bit shift
    assign shamt = operand_b[5:0];

    always_comb begin
        case (op)
            isa_pkg::ALU_SUB: result = rs1_data - operand_b;
            isa_pkg::ALU_AND: result = rs1_data & operand_b;
            isa_pkg::ALU_OR:  result = rs1_data | operand_b;
            isa_pkg::ALU_XOR: result = rs1_data ^ operand_b;
            isa_pkg::ALU_SHL: result = rs1_data << shamt;
            isa_pkg::ALU_SHR: result = rs1_data >> shamt;
            // Add, and the reserved code
            default:          result = rs1_data + operand_b;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_valid <= 1'b0;
        end else begin
            ex_valid <= issue;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            ex_rn     <= rd_rn;
            ex_result <= result;
            ex_pc     <= pc;
        end
    end

endmodule

`default_nettype wire

// ==== design/pipeline.sv ====
// In-order core pipeline top
`timescale 1ns/100ps
`default_nettype none

module pipeline #(
    parameter pipe_pkg::pc_t reset_pc = 64'h0
) (
    input  logic              clk,
    input  logic              rst_n,
    output pipe_pkg::pc_t     imem_addr,
    output logic              imem_addr_valid,
    input  isa_pkg::inst_t    imem_data,
    input  logic              imem_data_valid,
    output logic              retire_valid,
    output pipe_pkg::pc_t     retire_pc,
    output isa_pkg::reg_idx_t retire_rn,
    output isa_pkg::word_t    retire_data
);

    // Fetch to decode
    isa_pkg::inst_t fe_inst;
    pipe_pkg::pc_t  fe_pc;
    logic           fe_valid;
    logic           de_ready;

    // Decode outputs
    isa_pkg::reg_idx_t   rs1_rn;
    isa_pkg::reg_idx_t   rs2_rn;
    isa_pkg::reg_idx_t   rd_rn;
    isa_pkg::alu_op_t    op;
    logic                imm_form;
    isa_pkg::word_t      imm;
    pipe_pkg::pc_t       de_pc;
    logic                issue;
    pipe_pkg::busy_vec_t busy_vec;

    // Register reads and execute results
    isa_pkg::word_t    rs1_data;
    isa_pkg::word_t    rs2_data;
    logic              ex_valid;
    isa_pkg::reg_idx_t ex_rn;
    isa_pkg::word_t    ex_result;
    pipe_pkg::pc_t     ex_pc;

    fetch #(
        .reset_pc(reset_pc)
    ) i_fetch (
        .clk(clk), .rst_n(rst_n),
        .imem_addr(imem_addr), .imem_addr_valid(imem_addr_valid),
        .imem_data(imem_data), .imem_data_valid(imem_data_valid),
        .fe_inst(fe_inst), .fe_pc(fe_pc), .fe_valid(fe_valid), .de_ready(de_ready)
    );

    decode i_decode (
        .clk(clk), .rst_n(rst_n),
        .fe_inst(fe_inst), .fe_pc(fe_pc), .fe_valid(fe_valid), .de_ready(de_ready),
        .rs1_rn(rs1_rn), .rs2_rn(rs2_rn), .rd_rn(rd_rn), .op(op),
        .imm_form(imm_form), .imm(imm), .pc(de_pc),
        .busy_vec(busy_vec), .issue(issue)
    );

    // Writeback reuses the retire nets directly
    regfile i_regfile (
        .clk(clk), .rst_n(rst_n),
        .rs1_rn(rs1_rn), .rs2_rn(rs2_rn), .rs1_data(rs1_data), .rs2_data(rs2_data),
        .wb_en(retire_valid), .wb_rn(retire_rn), .wb_data(retire_data)
    );

    scoreboard i_scoreboard (
        .clk(clk), .rst_n(rst_n),
        .issue(issue), .rd_rn(rd_rn),
        .wb_en(retire_valid), .wb_rn(retire_rn), .busy_vec(busy_vec)
    );

    ex_alu i_ex_alu (
        .clk(clk), .rst_n(rst_n),
        .issue(issue), .op(op), .imm_form(imm_form), .imm(imm),
        .rd_rn(rd_rn), .pc(de_pc), .rs1_data(rs1_data), .rs2_data(rs2_data),
        .ex_valid(ex_valid), .ex_rn(ex_rn), .ex_result(ex_result), .ex_pc(ex_pc)
    );

    commit i_commit (
        .clk(clk), .rst_n(rst_n),
        .ex_valid(ex_valid), .ex_rn(ex_rn), .ex_result(ex_result), .ex_pc(ex_pc),
        .wb_en(retire_valid), .wb_rn(retire_rn), .wb_data(retire_data),
        .retire_pc(retire_pc)
    );

endmodule

`default_nettype wire

// ==== design/regfile.sv ====
// Architectural register file
`timescale 1ns/100ps
`default_nettype none

module regfile (
    input  logic              clk,
    input  logic              rst_n,
    input  isa_pkg::reg_idx_t rs1_rn,
    input  isa_pkg::reg_idx_t rs2_rn,
    output isa_pkg::word_t    rs1_data,
    output isa_pkg::word_t    rs2_data,
    input  logic              wb_en,
    input  isa_pkg::reg_idx_t wb_rn,
    input  isa_pkg::word_t    wb_data
);

    isa_pkg::word_t regs [isa_pkg::NUM_REGS];

    // r0 is hardwired to zero
    assign rs1_data = (rs1_rn == '0) ? '0 : regs[rs1_rn];
    assign rs2_data = (rs2_rn == '0) ? '0 : regs[rs2_rn];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < isa_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en && (wb_rn != '0)) begin
            regs[wb_rn] <= wb_data;
        end
    end

endmodule

`default_nettype wire

// ==== design/scoreboard.sv ====
// Register busy scoreboard
`timescale 1ns/100ps
`default_nettype none

module scoreboard (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                issue,
    input  isa_pkg::reg_idx_t   rd_rn,
    input  logic                wb_en,
    input  isa_pkg::reg_idx_t   wb_rn,
    output pipe_pkg::busy_vec_t busy_vec
);

    pipe_pkg::busy_vec_t busy_q;

    assign busy_vec = busy_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q <= '0;
        end else begin
            // Release first so a same-cycle issue to that register wins
            if (wb_en) begin
                busy_q[wb_rn] <= 1'b0;
            end
            if (issue) begin
                busy_q[rd_rn] <= 1'b1;
            end
            // r0 never blocks issue
            busy_q[0] <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== fetch/fetch.sv ====
// Instruction fetch unit
`timescale 1ns/100ps
`default_nettype none

module fetch #(
    parameter pipe_pkg::pc_t reset_pc = '0
) (
    input  logic           clk,
    input  logic           rst_n,
    output pipe_pkg::pc_t  imem_addr,
    output logic           imem_addr_valid,
    input  isa_pkg::inst_t imem_data,
    input  logic           imem_data_valid,
    output isa_pkg::inst_t fe_inst,
    output pipe_pkg::pc_t  fe_pc,
    output logic           fe_valid,
    input  logic           de_ready
);

    typedef enum logic [1:0] {
        ST_REQUEST,
        ST_WAIT_RELEASE,
        ST_HOLD
    } fetch_state_t;

    fetch_state_t  state;
    pipe_pkg::pc_t pc;
    logic          capture;
    logic          accept;

    // Word arrives while our request is still up
    assign capture = (state == ST_REQUEST) && imem_addr_valid && imem_data_valid;
    assign accept  = fe_valid && de_ready;

    // PC only moves after decode takes the word, so the address stays stable
    assign imem_addr = pc;
    assign fe_pc     = pc;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state           <= ST_REQUEST;
            pc              <= reset_pc;
            imem_addr_valid <= 1'b0;
            fe_valid        <= 1'b0;
        end else begin
            if (accept) begin
                pc       <= pc + pipe_pkg::INST_BYTES;
                fe_valid <= 1'b0;
            end
            case (state)
                ST_REQUEST: begin
                    if (capture) begin
                        imem_addr_valid <= 1'b0;
                        fe_valid        <= 1'b1;
                        state           <= ST_WAIT_RELEASE;
                    end else if (!imem_data_valid) begin
                        imem_addr_valid <= 1'b1;
                    end
                end
                ST_WAIT_RELEASE: begin
                    // Memory must drop its valid before the next request
                    if (!imem_data_valid) begin
                        state <= (fe_valid && !accept) ? ST_HOLD : ST_REQUEST;
                    end
                end
                ST_HOLD: begin
                    if (accept) begin
                        state <= ST_REQUEST;
                    end
                end
                default: state <= ST_REQUEST;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            fe_inst <= imem_data;
        end
    end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+tests
common/isa_pkg.sv
common/pipe_pkg.sv
fetch/fetch.sv
design/decode.sv
design/regfile.sv
design/scoreboard.sv
design/ex_alu.sv
design/commit.sv
design/pipeline.sv
tests/tb_pipeline.sv

// ==== tests/tb_ref_model.svh ====
// Reference ISA model and encoders
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// All 64 architectural registers of the model
typedef logic [63:0][63:0] model_regs_t;

// Register-register form
function automatic isa_pkg::inst_t enc_rr(input logic [2:0] op,
                                          input isa_pkg::reg_idx_t rd,
                                          input isa_pkg::reg_idx_t rs1,
                                          input isa_pkg::reg_idx_t rs2);
    return {1'b0, op, rd, rs1, rs2, 10'd0};
endfunction

// Register-immediate form
function automatic isa_pkg::inst_t enc_ri(input logic [2:0] op,
                                          input isa_pkg::reg_idx_t rd,
                                          input isa_pkg::reg_idx_t rs1,
                                          input logic [15:0] imm16);
    return {1'b1, op, rd, rs1, imm16};
endfunction

// Executes one instruction on the model state and returns its result
function automatic isa_pkg::word_t model_step(input isa_pkg::inst_t inst,
                                              inout model_regs_t regs);
    isa_pkg::reg_idx_t rd;
    isa_pkg::reg_idx_t rs1;
    isa_pkg::reg_idx_t rs2;
    isa_pkg::word_t    a;
    isa_pkg::word_t    b;
    isa_pkg::word_t    r;
    rd  = inst[27:22];
    rs1 = inst[21:16];
    rs2 = inst[15:10];
    a   = (rs1 == 6'd0) ? 64'd0 : regs[rs1];
    if (inst[31]) begin
        b = {{48{inst[15]}}, inst[15:0]};
    end else begin
        b = (rs2 == 6'd0) ? 64'd0 : regs[rs2];
    end
    case (inst[30:28])
        3'd1:    r = a - b;
        3'd2:    r = a & b;
        3'd3:    r = a | b;
        3'd4:    r = a ^ b;
        3'd5:    r = a << b[5:0];
        3'd6:    r = a >> b[5:0];
        // Add and the reserved code
        default: r = a + b;
    endcase
    if (rd != 6'd0) begin
        regs[rd] = r;
    end
    return r;
endfunction

`endif

// ==== tests/tb_pipeline.sv ====
// Pipeline testbench
`timescale 1ns/100ps
`default_nettype none

module tb_pipeline;

    localparam pipe_pkg::pc_t RESET_PC  = 64'h100;
    localparam int            MEM_WORDS = 256;
    localparam int            START_IDX = 64;
    localparam int            TIMEOUT   = 200;

    `include "tb_ref_model.svh"

    logic              clk = 1'b0;
    logic              rst_n;
    pipe_pkg::pc_t     imem_addr;
    logic              imem_addr_valid;
    isa_pkg::inst_t    imem_data;
    logic              imem_data_valid;
    logic              retire_valid;
    pipe_pkg::pc_t     retire_pc;
    isa_pkg::reg_idx_t retire_rn;
    isa_pkg::word_t    retire_data;

    isa_pkg::inst_t prog_mem [MEM_WORDS];
    string          prog_name [MEM_WORDS];
    int             prog_len;
    int             retired;
    integer         seed;
    model_regs_t    model_regs;

    // Bus monitor state
    logic          dv_at_edge;
    logic          rst_at_edge;
    logic          prev_av;
    pipe_pkg::pc_t prev_addr;
    logic          first_req_seen;
    int            cycles_after_reset;

    pipeline #(
        .reset_pc(RESET_PC)
    ) i_pipeline (
        .clk(clk), .rst_n(rst_n),
        .imem_addr(imem_addr), .imem_addr_valid(imem_addr_valid),
        .imem_data(imem_data), .imem_data_valid(imem_data_valid),
        .retire_valid(retire_valid), .retire_pc(retire_pc),
        .retire_rn(retire_rn), .retire_data(retire_data)
    );

    always #10 clk = ~clk;

    task automatic abort_run(input string why);
        if (why != "") begin
            $display("%s", why);
        end
        $display("TEST FAIL");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            $display("ERR %s expected %h actual %h", name, expected, actual);
            abort_run("");
        end
    endtask

    function automatic logic [15:0] rand16();
        logic [31:0] r;
        r = $random(seed);
        return r[15:0];
    endfunction

    // Source register among the loaded ones r1 to r4
    function automatic isa_pkg::reg_idx_t pick_src();
        logic [31:0]       r;
        isa_pkg::reg_idx_t idx;
        r   = $random(seed);
        idx = 6'd1 + r[1:0];
        return idx;
    endfunction

    task automatic emit(input isa_pkg::inst_t inst, input string name);
        prog_mem[START_IDX + prog_len]  = inst;
        prog_name[START_IDX + prog_len] = name;
        prog_len++;
    endtask

    // Builds a 64-bit value in 16-bit steps as a back-to-back chain
    task automatic load_random(input isa_pkg::reg_idx_t rd);
        emit(enc_ri(isa_pkg::ALU_ADD, rd, 6'd0, rand16()), "load");
        repeat (3) begin
            emit(enc_ri(isa_pkg::ALU_SHL, rd, rd, 16'd16), "load");
            emit(enc_ri(isa_pkg::ALU_XOR, rd, rd, rand16()), "load");
        end
    endtask

    task automatic build_program();
        int                i;
        logic [15:0]       imm;
        isa_pkg::reg_idx_t rd;
        for (i = 1; i <= 4; i++) begin
            rd = 6'(i);
            load_random(rd);
        end
        // Every op code including the reserved one
        for (i = 0; i < 16; i++) begin
            rd = 6'(8 + i);
            emit(enc_rr(i[2:0], rd, pick_src(), pick_src()), "reg_reg");
        end
        // First half with negative immediates
        for (i = 0; i < 16; i++) begin
            imm = rand16();
            if (i < 8) begin
                imm[15] = 1'b1;
            end
            rd = 6'(24 + i);
            emit(enc_ri(i[2:0], rd, pick_src(), imm), "imm");
        end
        emit(enc_ri(isa_pkg::ALU_ADD, 6'd40, 6'd0, 16'hfffb), "imm");
        emit(enc_ri(isa_pkg::ALU_SHL, 6'd41, 6'd1, 16'h0043), "imm");
        emit(enc_ri(isa_pkg::ALU_SHR, 6'd42, 6'd2, 16'hffc1), "imm");
        // Each step reads the previous destination
        emit(enc_rr(isa_pkg::ALU_ADD, 6'd44, 6'd1, 6'd2), "chain");
        for (i = 0; i < 10; i++) begin
            imm = rand16();
            if (i % 2 == 0) begin
                emit(enc_rr(imm[2:0], 6'd44, 6'd44, pick_src()), "chain");
            end else begin
                emit(enc_ri(imm[2:0], 6'd44, 6'd44, rand16()), "chain");
            end
        end
        emit(enc_rr(isa_pkg::ALU_SUB, 6'd45, 6'd1, 6'd44), "chain");
        emit(enc_ri(isa_pkg::ALU_ADD, 6'd45, 6'd45, 16'h0123), "chain");
        // r0 writes retire but never stick
        emit(enc_rr(isa_pkg::ALU_ADD, 6'd0, 6'd1, 6'd2), "r0");
        emit(enc_rr(isa_pkg::ALU_SUB, 6'd0, 6'd3, 6'd4), "r0");
        emit(enc_rr(isa_pkg::ALU_OR, 6'd46, 6'd0, 6'd0), "r0");
        emit(enc_ri(isa_pkg::ALU_ADD, 6'd47, 6'd0, 16'h0007), "r0");
        emit(enc_rr(isa_pkg::ALU_XOR, 6'd48, 6'd4, 6'd0), "r0");
    endtask

    // Past the end of the program memory answers add r0,r0,r0
    function automatic isa_pkg::inst_t program_word(input pipe_pkg::pc_t addr);
        pipe_pkg::pc_t idx;
        idx = addr >> 2;
        if (idx >= START_IDX && idx < START_IDX + prog_len) begin
            return prog_mem[idx];
        end else begin
            return enc_rr(isa_pkg::ALU_ADD, 6'd0, 6'd0, 6'd0);
        end
    endfunction

    initial begin : mem_responder
        int          cycles;
        logic [31:0] delay;
        forever begin
            cycles = 0;
            while (imem_addr_valid !== 1'b1) begin
                @(negedge clk);
                cycles++;
                if (cycles > TIMEOUT) begin
                    abort_run("Fetch raised no instruction request in time");
                end
            end
            delay = $random(seed);
            repeat (delay % 6) @(negedge clk);
            imem_data       = program_word(imem_addr);
            imem_data_valid = 1'b1;
            cycles = 0;
            while (imem_addr_valid !== 1'b0) begin
                @(negedge clk);
                cycles++;
                if (cycles > TIMEOUT) begin
                    abort_run("Fetch never dropped imem_addr_valid after the data");
                end
            end
            // Release also comes after a random delay
            delay = $random(seed);
            repeat (delay % 6) @(negedge clk);
            imem_data_valid = 1'b0;
        end
    end

    always begin : bus_monitor
        @(posedge clk);
        dv_at_edge  = imem_data_valid;
        rst_at_edge = rst_n;
        @(negedge clk);
        if (!rst_at_edge) begin
            if (imem_addr_valid !== 1'b0) begin
                abort_run("imem_addr_valid was not low during reset");
            end
            cycles_after_reset = 0;
        end else begin
            cycles_after_reset++;
            if (imem_addr_valid && !first_req_seen) begin
                check_value("reset first address", RESET_PC, imem_addr);
                check_value("reset first request cycle", 64'd1, cycles_after_reset);
                first_req_seen = 1'b1;
            end
            if (prev_av && imem_addr_valid && imem_addr !== prev_addr) begin
                abort_run("imem_addr changed while imem_addr_valid was high");
            end
            if (!prev_av && imem_addr_valid && dv_at_edge) begin
                abort_run("imem_addr_valid rose while imem_data_valid was still high");
            end
        end
        prev_av   = imem_addr_valid;
        prev_addr = imem_addr;
    end

    // Retired instructions come back in program order
    always @(negedge clk) begin : retire_checker
        int             idx;
        isa_pkg::inst_t inst;
        isa_pkg::word_t exp_data;
        if (retire_valid === 1'b1 && retired < prog_len) begin
            idx      = START_IDX + retired;
            inst     = prog_mem[idx];
            exp_data = model_step(inst, model_regs);
            check_value({prog_name[idx], " pc"}, RESET_PC + 4 * retired, retire_pc);
            check_value({prog_name[idx], " rn"}, inst[27:22], retire_rn);
            check_value({prog_name[idx], " data"}, exp_data, retire_data);
            retired++;
        end
    end

    initial begin : main_flow
        int idle;
        int last_retired;
        rst_n              = 1'b0;
        imem_data          = '0;
        imem_data_valid    = 1'b0;
        seed               = 32'h3d4b_d307;
        prog_len           = 0;
        retired            = 0;
        model_regs         = '0;
        prev_av            = 1'b0;
        prev_addr          = '0;
        first_req_seen     = 1'b0;
        cycles_after_reset = 0;
        build_program();
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        idle         = 0;
        last_retired = 0;
        while (retired < prog_len && idle < TIMEOUT) begin
            @(posedge clk);
            if (retired != last_retired) begin
                idle         = 0;
                last_retired = retired;
            end else begin
                idle++;
            end
        end
        if (retired == prog_len) begin
            $display("TEST PASS");
            $finish;
        end else begin
            abort_run("Instructions stopped retiring before the end of the program");
        end
    end

endmodule

`default_nettype wire
